//--- logic/regfile_pkg.sv
package regfile_pkg;

	// ==========================================================
	// Sizes of the register file
	// ==========================================================

	// Number of physical registers, each bank holds a full copy
	// of this address space
	localparam int pregs = 64;

	// Each write port owns exactly one bank, so this is also
	// the number of banks behind every read port
	localparam int wports = 4;

	// ==========================================================
	// Word types
	// ==========================================================

	// Physical register number, register 0 is the hardwired zero
	typedef logic [$clog2(pregs)-1:0] pregno_t;

	// One register value
	typedef logic [63:0] value_t;

	// Names a bank, which is the same as naming the write port
	// that last wrote a register
	typedef logic [$clog2(wports)-1:0] bank_sel_t;

endpackage

//--- logic/rf_bank_ram.sv
module rf_bank_ram #(
	parameter int read_ports = 4
) (
	input  logic                                   clk,
	input  logic                                   wr,
	input  regfile_pkg::pregno_t                   wa,
	input  regfile_pkg::value_t                    din,
	input  regfile_pkg::pregno_t [read_ports-1:0]  ra,
	output regfile_pkg::value_t  [read_ports-1:0]  dout
);

	import regfile_pkg::*;

	// ==========================================================
	// Storage
	// ==========================================================

	// One word per physical register. A bank only ever sees the
	// writes of its own port, so its copy of a register can be
	// stale and the live value table decides whether it counts
	value_t mem [pregs];

	// Single write port, taken at the rising edge whenever the
	// strobe is high
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wa] <= din;
		end
	end

	// ==========================================================
	// Read ports
	// ==========================================================

	// Every read port sees the array directly, no output register.
	// A write in this cycle is not visible here until after the
	// edge, the read selector covers that case by bypass
	always_comb begin
		for (int p = 0; p < read_ports; p++) begin
			dout[p] = mem[ra[p]];
		end
	end

endmodule

//--- logic/rf_live_value_table.sv
module rf_live_value_table #(
	parameter int read_ports = 4
) (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic                                     wr0,
	input  logic                                     wr1,
	input  logic                                     wr2,
	input  logic                                     wr3,
	input  regfile_pkg::pregno_t                     wa0,
	input  regfile_pkg::pregno_t                     wa1,
	input  regfile_pkg::pregno_t                     wa2,
	input  regfile_pkg::pregno_t                     wa3,
	input  regfile_pkg::pregno_t    [read_ports-1:0] ra,
	output regfile_pkg::bank_sel_t  [read_ports-1:0] sel
);

	import regfile_pkg::*;

	// Write strobes and addresses gathered by port number so the
	// update can walk them in order
	logic    wr_v [wports];
	pregno_t wa_v [wports];

	// One bank number per physical register
	bank_sel_t lvt [pregs];

	assign wr_v = '{wr0, wr1, wr2, wr3};
	assign wa_v = '{wa0, wa1, wa2, wa3};

	// ==========================================================
	// Table update
	// ==========================================================

	// After reset every register is owned by bank 0.
	// Ports are visited from 0 upward and each strobing port
	// records its own number at its address. When two ports hit
	// the same register the later assignment stands, so the
	// highest-numbered port owns the entry
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < pregs; r++) begin
				lvt[r] <= '0;
			end
		end else begin
			for (int w = 0; w < wports; w++) begin
				if (wr_v[w]) begin
					lvt[wa_v[w]] <= bank_sel_t'(w);
				end
			end
		end
	end

	// ==========================================================
	// Lookup
	// ==========================================================

	// Combinational lookup for every read port, this reflects the
	// writes up to the last edge only
	always_comb begin
		for (int p = 0; p < read_ports; p++) begin
			sel[p] = lvt[ra[p]];
		end
	end

	// Port 3 has top priority, so the edge after it writes a
	// register the table must name bank 3 for that register, no
	// matter what the other ports did in the same cycle
	assert property (@(posedge clk) disable iff (rst)
		wr3 |=> lvt[$past(wa3)] == bank_sel_t'(wports - 1));

endmodule

//--- logic/rf_read_select.sv
module rf_read_select #(
	parameter int read_ports = 4
) (
	input  regfile_pkg::pregno_t    [read_ports-1:0] ra,
	input  logic                                     wr0,
	input  logic                                     wr1,
	input  logic                                     wr2,
	input  logic                                     wr3,
	input  regfile_pkg::pregno_t                     wa0,
	input  regfile_pkg::pregno_t                     wa1,
	input  regfile_pkg::pregno_t                     wa2,
	input  regfile_pkg::pregno_t                     wa3,
	input  regfile_pkg::value_t                      i0,
	input  regfile_pkg::value_t                      i1,
	input  regfile_pkg::value_t                      i2,
	input  regfile_pkg::value_t                      i3,
	input  regfile_pkg::value_t     [read_ports-1:0] bank_dout0,
	input  regfile_pkg::value_t     [read_ports-1:0] bank_dout1,
	input  regfile_pkg::value_t     [read_ports-1:0] bank_dout2,
	input  regfile_pkg::value_t     [read_ports-1:0] bank_dout3,
	input  regfile_pkg::bank_sel_t  [read_ports-1:0] sel,
	output regfile_pkg::value_t     [read_ports-1:0] o
);

	import regfile_pkg::*;

	// Write ports and bank outputs gathered by port number, so the
	// selection below can index them with a loop or with sel
	logic                     wr_v   [wports];
	pregno_t                  wa_v   [wports];
	value_t                   i_v    [wports];
	value_t  [read_ports-1:0] dout_v [wports];

	assign wr_v   = '{wr0, wr1, wr2, wr3};
	assign wa_v   = '{wa0, wa1, wa2, wa3};
	assign i_v    = '{i0, i1, i2, i3};
	assign dout_v = '{bank_dout0, bank_dout1, bank_dout2, bank_dout3};

	// ==========================================================
	// Per-port selection
	// ==========================================================

	// Three levels, each overriding the one before it.
	// First the bank that the live value table names.
	// Then any same-cycle write to the address, visited from
	// port 0 upward so the highest matching port is left standing.
	// Last the zero register, which beats everything
	always_comb begin
		for (int p = 0; p < read_ports; p++) begin
			o[p] = dout_v[sel[p]][p];
			for (int w = 0; w < wports; w++) begin
				if (wr_v[w] && wa_v[w] == ra[p]) begin
					o[p] = i_v[w];
				end
			end
			if (ra[p] == '0) begin
				o[p] = '0;
			end
		end
	end

endmodule

//--- logic/regfile_4w.sv
module regfile_4w #(
	parameter int read_ports = 4
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   wr0,
	input  logic                                   wr1,
	input  logic                                   wr2,
	input  logic                                   wr3,
	input  regfile_pkg::pregno_t                   wa0,
	input  regfile_pkg::pregno_t                   wa1,
	input  regfile_pkg::pregno_t                   wa2,
	input  regfile_pkg::pregno_t                   wa3,
	input  regfile_pkg::value_t                    i0,
	input  regfile_pkg::value_t                    i1,
	input  regfile_pkg::value_t                    i2,
	input  regfile_pkg::value_t                    i3,
	input  regfile_pkg::pregno_t [read_ports-1:0]  ra,
	output regfile_pkg::value_t  [read_ports-1:0]  o
);

	import regfile_pkg::*;

	// Every bank answers every read port, indexed by bank number
	value_t [read_ports-1:0] bank_dout [wports];

	// Which bank holds the newest copy of each read address
	bank_sel_t [read_ports-1:0] lvt_sel;

	// ==========================================================
	// Banks, one per write port
	// ==========================================================

	// Each bank is a full copy of the register space written by
	// a single port, which keeps every RAM to one write port
	rf_bank_ram #(.read_ports(read_ports)) bank0 (
		.clk  (clk),
		.wr   (wr0),
		.wa   (wa0),
		.din  (i0),
		.ra   (ra),
		.dout (bank_dout[0])
	);

	rf_bank_ram #(.read_ports(read_ports)) bank1 (
		.clk  (clk),
		.wr   (wr1),
		.wa   (wa1),
		.din  (i1),
		.ra   (ra),
		.dout (bank_dout[1])
	);

	rf_bank_ram #(.read_ports(read_ports)) bank2 (
		.clk  (clk),
		.wr   (wr2),
		.wa   (wa2),
		.din  (i2),
		.ra   (ra),
		.dout (bank_dout[2])
	);

	rf_bank_ram #(.read_ports(read_ports)) bank3 (
		.clk  (clk),
		.wr   (wr3),
		.wa   (wa3),
		.din  (i3),
		.ra   (ra),
		.dout (bank_dout[3])
	);

	// ==========================================================
	// Live value table and output selection
	// ==========================================================

	// Tracks the last writer of every register
	rf_live_value_table #(.read_ports(read_ports)) lvt (
		.clk (clk),
		.rst (rst),
		.wr0 (wr0),
		.wr1 (wr1),
		.wr2 (wr2),
		.wr3 (wr3),
		.wa0 (wa0),
		.wa1 (wa1),
		.wa2 (wa2),
		.wa3 (wa3),
		.ra  (ra),
		.sel (lvt_sel)
	);

	// Zero register, same-cycle bypass, then the selected bank
	rf_read_select #(.read_ports(read_ports)) rsel (
		.ra         (ra),
		.wr0        (wr0),
		.wr1        (wr1),
		.wr2        (wr2),
		.wr3        (wr3),
		.wa0        (wa0),
		.wa1        (wa1),
		.wa2        (wa2),
		.wa3        (wa3),
		.i0         (i0),
		.i1         (i1),
		.i2         (i2),
		.i3         (i3),
		.bank_dout0 (bank_dout[0]),
		.bank_dout1 (bank_dout[1]),
		.bank_dout2 (bank_dout[2]),
		.bank_dout3 (bank_dout[3]),
		.sel        (lvt_sel),
		.o          (o)
	);

endmodule

//--- sim/regfile_4w_tb.sv
module regfile_4w_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import regfile_pkg::*;

	localparam int read_ports = 4;
	localparam int reset_cycles = 4;
	localparam int max_lines = 256;
	// Outputs are sampled this long after the driving edge, just ahead of the next one
	localparam int check_delay = 8;
	localparam string test_file = "sim/regfile_4w_tests.txt";

	logic                        clk;
	logic                        rst;
	logic                        wr0;
	logic                        wr1;
	logic                        wr2;
	logic                        wr3;
	pregno_t                     wa0;
	pregno_t                     wa1;
	pregno_t                     wa2;
	pregno_t                     wa3;
	value_t                      i0;
	value_t                      i1;
	value_t                      i2;
	value_t                      i3;
	pregno_t   [read_ports-1:0]  ra;
	value_t    [read_ports-1:0]  o;

	// One entry per test line, data and expected values are generator step indices
	logic [3:0] t_mask [max_lines];
	pregno_t    t_wa   [max_lines][wports];
	logic [7:0] t_data [max_lines][wports];
	pregno_t    t_ra   [max_lines][read_ports];
	logic [7:0] t_exp  [max_lines][read_ports];

	// Step index to value, index 0 stands for the value zero
	value_t data_tab [256];

	int n_lines = 0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 0;

	regfile_4w #(.read_ports(read_ports)) UUT (
		.clk (clk),
		.rst (rst),
		.wr0 (wr0),
		.wr1 (wr1),
		.wr2 (wr2),
		.wr3 (wr3),
		.wa0 (wa0),
		.wa1 (wa1),
		.wa2 (wa2),
		.wa3 (wa3),
		.i0  (i0),
		.i1  (i1),
		.i2  (i2),
		.i3  (i3),
		.ra  (ra),
		.o   (o)
	);

	// ==========================================================
	// Clock and run limit
	// ==========================================================

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Counting starts once the test file is loaded and the limit is known
	always @(posedge clk) begin
		if (cycle_limit != 0) begin
			cycles++;
			if (cycles >= cycle_limit) begin
				$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
				$display("Regression failed");
				$finish;
			end
		end
	end

	// ==========================================================
	// Helpers
	// ==========================================================

	// 32-bit linear congruential step
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Each value takes two generator steps, high word first
	task automatic build_data_table();
		logic [31:0] state;
		logic [31:0] hi;
		state = 32'hdcfa_e024;
		data_tab[0] = '0;
		for (int k = 1; k < 256; k++) begin
			state = lcg_next(state);
			hi = state;
			state = lcg_next(state);
			data_tab[k] = {hi, state};
		end
	endtask

	// Lines that start with # hold the column description
	task automatic load_tests();
		int         fd;
		int         code;
		int         fields;
		string      line;
		logic [7:0] f [17];
		fd = $fopen(test_file, "r");
		if (fd == 0) begin
			$display("Could not open the test file %s", test_file);
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
				f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
			if (fields != 17) begin
				$display("A test file line could not be read: %s", line);
				errors++;
				continue;
			end
			if (n_lines == max_lines) begin
				$display("The test file holds more than %0d test lines", max_lines);
				errors++;
				break;
			end
			t_mask[n_lines] = f[0][3:0];
			for (int w = 0; w < wports; w++) begin
				t_wa[n_lines][w] = pregno_t'(f[1 + w]);
				t_data[n_lines][w] = f[5 + w];
			end
			for (int p = 0; p < read_ports; p++) begin
				t_ra[n_lines][p] = pregno_t'(f[9 + p]);
				t_exp[n_lines][p] = f[13 + p];
			end
			n_lines++;
		end
		$fclose(fd);
	endtask

	// Called right after a rising edge, so the DUT sees these from the next edge on
	task automatic drive_line(input int n);
		wr0 <= t_mask[n][0];
		wr1 <= t_mask[n][1];
		wr2 <= t_mask[n][2];
		wr3 <= t_mask[n][3];
		wa0 <= t_wa[n][0];
		wa1 <= t_wa[n][1];
		wa2 <= t_wa[n][2];
		wa3 <= t_wa[n][3];
		i0 <= data_tab[t_data[n][0]];
		i1 <= data_tab[t_data[n][1]];
		i2 <= data_tab[t_data[n][2]];
		i3 <= data_tab[t_data[n][3]];
		for (int p = 0; p < read_ports; p++) begin
			ra[p] <= t_ra[n][p];
		end
	endtask

	task automatic check_value(input string name, input int n, input value_t expected,
		input value_t actual);
		checks++;
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h (test line %0d)",
				name, expected, actual, n);
			errors++;
		end
	endtask

	// ==========================================================
	// Test sequence
	// ==========================================================

	initial begin
		rst = 1'b1;
		wr0 = 1'b0;
		wr1 = 1'b0;
		wr2 = 1'b0;
		wr3 = 1'b0;
		wa0 = '0;
		wa1 = '0;
		wa2 = '0;
		wa3 = '0;
		i0 = '0;
		i1 = '0;
		i2 = '0;
		i3 = '0;
		ra = '0;
		build_data_table();
		load_tests();
		if (n_lines == 0) begin
			$display("No test lines were loaded, nothing was run");
			errors++;
		end
		cycle_limit = n_lines + reset_cycles + 20;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		for (int n = 0; n < n_lines; n++) begin
			@(posedge clk);
			drive_line(n);
			#(check_delay);
			for (int p = 0; p < read_ports; p++) begin
				check_value($sformatf("o[%0d]", p), n, data_tab[t_exp[n][p]], o[p]);
			end
		end
		@(posedge clk);
		$display("Test lines: %0d, checks: %0d, errors: %0d", n_lines, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- sim/regfile_4w_tests.txt
# mask wa0 wa1 wa2 wa3 d0 d1 d2 d3 ra0 ra1 ra2 ra3 e0 e1 e2 e3 (all hex)
# mask bit n strobes write port n; d and e are generator step indices, 00 means zero
1 01 00 00 00 01 00 00 00 00 00 00 00 00 00 00 00
2 00 02 00 00 00 02 00 00 01 00 00 00 01 00 00 00
4 00 00 03 00 00 00 03 00 01 02 00 00 01 02 00 00
8 00 00 00 04 00 00 00 04 01 02 03 00 01 02 03 00
0 00 00 00 00 00 00 00 00 04 03 02 01 04 03 02 01
0 00 00 00 00 00 00 00 00 01 01 04 04 01 01 04 04
1 05 00 00 00 05 00 00 00 05 00 00 00 05 00 00 00
2 00 06 00 00 00 06 00 00 00 06 00 00 00 06 00 00
4 00 00 07 00 00 00 07 00 00 00 07 05 00 00 07 05
8 00 00 00 08 00 00 00 08 08 07 06 08 08 07 06 08
1 01 00 00 00 09 00 00 00 01 01 02 03 09 09 02 03
0 02 03 04 05 0a 0b 0c 0d 02 03 04 05 02 03 04 05
f 10 10 10 10 0e 0f 10 11 10 10 00 00 11 11 00 00
0 00 00 00 00 00 00 00 00 10 10 10 10 11 11 11 11
7 11 11 11 11 12 13 14 15 11 00 00 00 14 00 00 00
3 12 12 00 00 16 17 00 00 12 11 00 00 17 14 00 00
9 13 00 00 13 18 00 00 19 13 12 11 10 19 17 14 11
6 00 14 14 00 00 1a 1b 00 14 13 12 11 1b 19 17 14
5 15 00 15 00 1c 00 1d 00 15 14 13 12 1d 1b 19 17
a 00 16 00 16 00 1e 00 1f 16 15 14 13 1f 1d 1b 19
c 00 00 17 17 00 00 20 21 17 16 15 14 21 1f 1d 1b
0 00 00 00 00 00 00 00 00 10 11 12 13 11 14 17 19
0 00 00 00 00 00 00 00 00 14 15 16 17 1b 1d 1f 21
f 18 18 19 19 22 23 24 25 18 19 18 19 23 25 23 25
0 00 00 00 00 00 00 00 00 18 19 00 00 23 25 00 00
1 00 00 00 00 26 00 00 00 00 00 00 00 00 00 00 00
0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
f 00 00 00 00 27 28 29 2a 00 00 00 00 00 00 00 00
0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
8 00 00 00 00 00 00 00 2b 00 01 00 02 00 09 00 02
4 00 00 01 00 00 00 2c 00 00 00 00 00 00 00 00 00
0 00 00 00 00 00 00 00 00 01 01 01 01 2c 2c 2c 2c
2 00 01 00 00 00 2d 00 00 01 00 00 00 2d 00 00 00
0 00 00 00 00 00 00 00 00 01 02 03 04 2d 02 03 04
8 00 00 00 02 00 00 00 2e 00 00 00 00 00 00 00 00
1 02 00 00 00 2f 00 00 00 02 00 00 00 2f 00 00 00
0 00 00 00 00 00 00 00 00 02 02 01 01 2f 2f 2d 2d
2 00 03 00 00 00 30 00 00 03 00 00 00 30 00 00 00
4 00 00 03 00 00 00 31 00 00 03 00 00 00 31 00 00
0 00 00 00 00 00 00 00 00 03 03 03 03 31 31 31 31
1 04 00 00 00 32 00 00 00 00 00 00 00 00 00 00 00
0 00 00 00 00 00 00 00 00 04 08 05 06 32 08 05 06
f 20 21 22 23 33 34 35 36 20 21 22 23 33 34 35 36
f 24 25 26 27 37 38 39 3a 23 22 21 20 36 35 34 33
f 20 21 22 23 3b 3c 3d 3e 27 26 25 24 3a 39 38 37
f 23 22 21 20 3f 40 41 42 20 21 22 23 42 41 40 3f
0 00 00 00 00 00 00 00 00 20 21 22 23 42 41 40 3f
f 3f 3e 3d 3c 43 44 45 46 3c 24 3f 26 46 37 43 39
0 00 00 00 00 00 00 00 00 3f 3e 3d 3c 43 44 45 46
f 01 02 03 04 47 48 49 4a 04 03 02 01 4a 49 48 47
0 00 00 00 00 00 00 00 00 01 02 03 04 47 48 49 4a
0 00 00 00 00 00 00 00 00 10 14 18 19 11 1b 23 25
0 00 00 00 00 00 00 00 00 05 06 07 08 05 06 07 08
0 00 00 00 00 00 00 00 00 15 16 17 3e 1d 1f 21 44

//--- regfile_4w.f
logic/regfile_pkg.sv
logic/rf_bank_ram.sv
logic/rf_live_value_table.sv
logic/rf_read_select.sv
logic/regfile_4w.sv
sim/regfile_4w_tb.sv

//--- Makefile
# Verilator build and run of the register file testbench

SIM := obj_dir/Vregfile_4w_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): regfile_4w.f $(wildcard logic/*.sv) $(wildcard sim/*.sv)
	verilator --binary --assert -j 0 --top-module regfile_4w_tb -f regfile_4w.f

# The run passes only when the log holds the pass line
run: $(SIM) sim/regfile_4w_tests.txt
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then exit 1; fi
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
